// ==== logic/mioc_pkg.sv ====
`default_nettype none

package mioc_pkg;

   localparam int SYNC_STAGES = 2;            // flops per async pin synchroniser
   localparam int IO_ADDR_W   = 8;            // z80 i/o space is 8 bit addressed
   localparam int IO_DATA_W   = 8;

   localparam logic [IO_ADDR_W-1:0] MEM_CFG_PORT = 8'h7F;  // memory map select
   localparam logic [IO_ADDR_W-1:0] CTL_PORT     = 8'h3F;  // net reset / spinner enable

   // lower 32 KB occupant
   typedef enum logic [1:0] {
      LO_SMARTWRITER = 2'd0,                  // boot rom
      LO_RAM         = 2'd1,                  // ram bank low
      LO_EXP_RAM     = 2'd2,                  // handed to aux decode
      LO_OS7         = 2'd3                   // 8 KB os7 via 245, rest ram low
   } mem_lo_e;

   // upper 32 KB occupant
   typedef enum logic [1:0] {
      HI_RAM         = 2'd0,                  // ram bank high
      HI_EXP_RAM     = 2'd1,                  // handed to aux decode
      HI_EXP_ROM     = 2'd2,                  // expansion rom slot
      HI_CART        = 2'd3                   // cartridge through onboard 245
   } mem_hi_e;

   typedef struct packed {
      mem_hi_e hi;                            // data bits 3..2
      mem_lo_e lo;                            // data bits 1..0
   } mem_cfg_t;

   typedef struct packed {
      logic spin_en;                          // data bit 1
      logic net_run;                          // data bit 0, 0 holds network in reset
   } ctl_t;

   localparam mem_cfg_t MEM_CFG_COMPUTER = '{hi: HI_RAM,  lo: LO_SMARTWRITER};
   localparam mem_cfg_t MEM_CFG_GAME     = '{hi: HI_CART, lo: LO_OS7};
   localparam ctl_t     CTL_RESET        = '{spin_en: 1'b0, net_run: 1'b0};

endpackage

`default_nettype wire

// ==== logic/mioc_reset_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module mioc_reset_ctrl (
   input  wire  b_phi,                        // z80 clock
   input  wire  rst_n,                        // power-on reset
   input  logic game_rst_n,                   // game reset pin, async
   input  logic pb_rst_n,                     // push-button reset pin, async
   output logic game_rst,                     // synchronised game reset, active high
   output logic sys_rst,                      // either reset active
   output logic sys_rst_n                     // system reset pin
);

   // bit 0 carries game reset, bit 1 the push-button, both stored active low
   logic [mioc_pkg::SYNC_STAGES-1:0][1:0] rst_sync;
   logic                                  pb_rst;     // synchronised push-button

   always_ff @(posedge b_phi or negedge rst_n) begin
      if (!rst_n) begin
         rst_sync <= '1;                      // inactive level so nothing fires at power-on
      end else begin
         rst_sync[0] <= {pb_rst_n, game_rst_n};
         for (int i = 1; i < mioc_pkg::SYNC_STAGES; i++) begin
            rst_sync[i] <= rst_sync[i-1];     // shift toward the output stage
         end
      end
   end

   assign game_rst  = ~rst_sync[mioc_pkg::SYNC_STAGES-1][0];
   assign pb_rst    = ~rst_sync[mioc_pkg::SYNC_STAGES-1][1];

   // system reset follows either source, no stretching
   assign sys_rst   = game_rst | pb_rst;
   assign sys_rst_n = ~sys_rst;

endmodule

`default_nettype wire

// ==== logic/mioc_io_port_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module mioc_io_port_reg #(
   parameter type                             payload_t  = logic [3:0],
   parameter logic [mioc_pkg::IO_ADDR_W-1:0]  PORT_ADDR  = '0,
   parameter payload_t                        PRESET_VAL = payload_t'(0),
   parameter payload_t                        RESET_VAL  = PRESET_VAL   // power-on value
) (
   input  wire                               b_phi,
   input  wire                               rst_n,
   input  logic                              preset,   // sync force to PRESET_VAL
   input  logic                              io_wr,    // one-cycle write strobe
   input  logic [mioc_pkg::IO_ADDR_W-1:0]    io_addr,
   input  logic [mioc_pkg::IO_DATA_W-1:0]    io_data,
   output payload_t                          value
);

   localparam int PW = $bits(payload_t);      // payload takes the low data bits

   logic hit;                                 // strobe aimed at this port

   assign hit = io_wr && (io_addr == PORT_ADDR);

   always_ff @(posedge b_phi or negedge rst_n) begin
      if (!rst_n) begin
         value <= RESET_VAL;
      end else if (preset) begin
         value <= PRESET_VAL;                 // preset wins over a write in the same cycle
      end else if (hit) begin
         value <= payload_t'(io_data[PW-1:0]);
      end
   end

endmodule

`default_nettype wire

// ==== logic/mioc_mem_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module mioc_mem_decode (
   input  wire                b_phi,
   input  wire                rst_n,
   input  logic [2:0]         addr_hi,        // address bits 15..13
   input  logic               mreq_n,
   input  logic               rfsh_n,         // refresh cycles never select anything
   input  mioc_pkg::mem_cfg_t mem_cfg,
   output logic               boot_rom_cs_n,  // smartwriter rom
   output logic               aux_rom_cs_n,   // expansion rom slot
   output logic               ram_lo_cas_n,   // ram bank low
   output logic               ram_hi_cas_n,   // ram bank high
   output logic               en245_n,        // onboard 245, os7 and cartridge
   output logic               aux_decode_n    // expansion ram owns the cycle
);

   // active-high select vector, order matches the output list
   typedef struct packed {
      logic boot_rom;
      logic aux_rom;
      logic ram_lo;
      logic ram_hi;
      logic en245;
      logic aux_decode;
   } sel_t;

   sel_t sel_d;                               // next selects
   sel_t sel_q;                               // registered selects

   always_comb begin
      sel_d = '0;
      if (!mreq_n && rfsh_n) begin
         if (!addr_hi[2]) begin               // lower 32 KB
            case (mem_cfg.lo)
               mioc_pkg::LO_SMARTWRITER: sel_d.boot_rom   = 1'b1;
               mioc_pkg::LO_RAM:         sel_d.ram_lo     = 1'b1;
               mioc_pkg::LO_EXP_RAM:     sel_d.aux_decode = 1'b1;
               mioc_pkg::LO_OS7: begin
                  if (addr_hi[1:0] == 2'b00) begin
                     sel_d.en245 = 1'b1;      // os7 rom in first 8 KB
                  end else begin
                     sel_d.ram_lo = 1'b1;     // 24 KB of ram above it
                  end
               end
               default:                  sel_d = '0;
            endcase
         end else begin                       // upper 32 KB
            case (mem_cfg.hi)
               mioc_pkg::HI_RAM:         sel_d.ram_hi     = 1'b1;
               mioc_pkg::HI_EXP_RAM:     sel_d.aux_decode = 1'b1;
               mioc_pkg::HI_EXP_ROM:     sel_d.aux_rom    = 1'b1;
               mioc_pkg::HI_CART:        sel_d.en245      = 1'b1;
               default:                  sel_d = '0;
            endcase
         end
      end
   end

   always_ff @(posedge b_phi or negedge rst_n) begin
      if (!rst_n) begin
         sel_q <= '0;                         // nothing selected out of reset
      end else begin
         sel_q <= sel_d;
      end
   end

   assign boot_rom_cs_n = ~sel_q.boot_rom;
   assign aux_rom_cs_n  = ~sel_q.aux_rom;
   assign ram_lo_cas_n  = ~sel_q.ram_lo;
   assign ram_hi_cas_n  = ~sel_q.ram_hi;
   assign en245_n       = ~sel_q.en245;
   assign aux_decode_n  = ~sel_q.aux_decode;

endmodule

`default_nettype wire

// ==== logic/mioc_bus_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mioc_bus_arbiter (
   input  wire  b_phi,
   input  wire  rst_n,
   input  logic dma_n,                        // dma request from the 6801, async
   input  logic busak_n,                      // z80 bus acknowledge
   output logic busrq_n,                      // z80 bus request
   output logic addrbufen_n                   // high floats the cpu address buffers
);

   logic [mioc_pkg::SYNC_STAGES-1:0] dma_sync;    // stored active low
   logic                             busrq_n_d;   // value busrq_n takes at the next edge
   logic                             grant_d;     // bus will be ours next cycle
   logic                             buf_off_q;

   always_ff @(posedge b_phi or negedge rst_n) begin
      if (!rst_n) begin
         dma_sync <= '1;                      // no request out of reset
      end else begin
         dma_sync <= {dma_sync[mioc_pkg::SYNC_STAGES-2:0], dma_n};
      end
   end

   assign busrq_n   = dma_sync[mioc_pkg::SYNC_STAGES-1];
   assign busrq_n_d = dma_sync[mioc_pkg::SYNC_STAGES-2];

   // use the upcoming request level so the buffers drop back on the
   // same edge that busrq_n is released
   assign grant_d = !busrq_n && !busrq_n_d && !busak_n;

   always_ff @(posedge b_phi or negedge rst_n) begin
      if (!rst_n) begin
         buf_off_q <= 1'b0;                   // buffers enabled
      end else begin
         buf_off_q <= grant_d;
      end
   end

   assign addrbufen_n = buf_off_q;

endmodule

`default_nettype wire

// ==== logic/mioc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mioc_top (
   input  wire                            b_phi,          // z80 clock
   input  wire                            rst_n,          // power-on reset
   input  logic                           game_rst_n,     // game reset pin
   input  logic                           pb_rst_n,       // push-button reset
   input  logic                           io_wr,          // i/o write strobe
   input  logic [mioc_pkg::IO_ADDR_W-1:0] io_addr,
   input  logic [mioc_pkg::IO_DATA_W-1:0] io_data,
   input  logic [2:0]                     addr_hi,        // address 15..13
   input  logic                           mreq_n,
   input  logic                           rfsh_n,
   input  logic                           dma_n,
   input  logic                           busak_n,
   output logic                           sys_rst_n,
   output logic                           netrst_n,       // adamnet reset
   output logic                           spindis_n,      // spinner disable
   output logic                           boot_rom_cs_n,
   output logic                           aux_rom_cs_n,
   output logic                           ram_lo_cas_n,
   output logic                           ram_hi_cas_n,
   output logic                           en245_n,
   output logic                           aux_decode_n,
   output logic                           busrq_n,
   output logic                           addrbufen_n
);

   logic               game_rst;              // presets the map to game mode
   logic               sys_rst;               // clears the control port
   mioc_pkg::mem_cfg_t mem_cfg;
   mioc_pkg::ctl_t     ctl;

   mioc_reset_ctrl u_reset (
      .b_phi      (b_phi),
      .rst_n      (rst_n),
      .game_rst_n (game_rst_n),
      .pb_rst_n   (pb_rst_n),
      .game_rst   (game_rst),
      .sys_rst    (sys_rst),
      .sys_rst_n  (sys_rst_n)
   );

   // power-on gives computer mode, game reset forces the os7/cartridge map
   mioc_io_port_reg #(
      .payload_t  (mioc_pkg::mem_cfg_t),
      .PORT_ADDR  (mioc_pkg::MEM_CFG_PORT),
      .PRESET_VAL (mioc_pkg::MEM_CFG_GAME),
      .RESET_VAL  (mioc_pkg::MEM_CFG_COMPUTER)
   ) u_mem_cfg (
      .b_phi   (b_phi),
      .rst_n   (rst_n),
      .preset  (game_rst),
      .io_wr   (io_wr),
      .io_addr (io_addr),
      .io_data (io_data),
      .value   (mem_cfg)
   );

   mioc_io_port_reg #(
      .payload_t  (mioc_pkg::ctl_t),
      .PORT_ADDR  (mioc_pkg::CTL_PORT),
      .PRESET_VAL (mioc_pkg::CTL_RESET)
   ) u_ctl (
      .b_phi   (b_phi),
      .rst_n   (rst_n),
      .preset  (sys_rst),
      .io_wr   (io_wr),
      .io_addr (io_addr),
      .io_data (io_data),
      .value   (ctl)
   );

   assign netrst_n  = ctl.net_run;            // low keeps adamnet in reset
   assign spindis_n = ctl.spin_en;

   mioc_mem_decode u_decode (
      .b_phi         (b_phi),
      .rst_n         (rst_n),
      .addr_hi       (addr_hi),
      .mreq_n        (mreq_n),
      .rfsh_n        (rfsh_n),
      .mem_cfg       (mem_cfg),
      .boot_rom_cs_n (boot_rom_cs_n),
      .aux_rom_cs_n  (aux_rom_cs_n),
      .ram_lo_cas_n  (ram_lo_cas_n),
      .ram_hi_cas_n  (ram_hi_cas_n),
      .en245_n       (en245_n),
      .aux_decode_n  (aux_decode_n)
   );

   mioc_bus_arbiter u_arbiter (
      .b_phi       (b_phi),
      .rst_n       (rst_n),
      .dma_n       (dma_n),
      .busak_n     (busak_n),
      .busrq_n     (busrq_n),
      .addrbufen_n (addrbufen_n)
   );

endmodule

`default_nettype wire

// ==== tests/mioc_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module mioc_checker (
   input wire b_phi,
   input wire rst_n,
   input wire dma_n,
   input wire busrq_n,
   input wire addrbufen_n,
   input wire boot_rom_cs_n,
   input wire aux_rom_cs_n,
   input wire ram_lo_cas_n,
   input wire ram_hi_cas_n,
   input wire en245_n,
   input wire aux_decode_n
);

   logic [2:0] settle;                        // edges since reset, saturates at 7

   always_ff @(posedge b_phi or negedge rst_n) begin
      if (!rst_n) begin
         settle <= '0;
      end else if (settle != 3'd7) begin
         settle <= settle + 3'd1;
      end
   end

   // two targets on the data bus at once
   a_one_select: assert property (@(posedge b_phi) disable iff (!rst_n)
      $onehot0({~boot_rom_cs_n, ~aux_rom_cs_n, ~ram_lo_cas_n,
                ~ram_hi_cas_n, ~en245_n, ~aux_decode_n}))
      else $error("more than one memory select active");

   a_busrq_delay: assert property (@(posedge b_phi) disable iff (!rst_n)
      (settle >= 3'(mioc_pkg::SYNC_STAGES))
         |-> (busrq_n == $past(dma_n, mioc_pkg::SYNC_STAGES)))
      else $error("busrq_n does not follow dma_n after the synchroniser delay");

   a_buf_off_granted: assert property (@(posedge b_phi) disable iff (!rst_n)
      addrbufen_n |-> !busrq_n)
      else $error("address buffers disabled without a bus request");

endmodule

bind mioc_top mioc_checker u_checker (
   .b_phi         (b_phi),
   .rst_n         (rst_n),
   .dma_n         (dma_n),
   .busrq_n       (busrq_n),
   .addrbufen_n   (addrbufen_n),
   .boot_rom_cs_n (boot_rom_cs_n),
   .aux_rom_cs_n  (aux_rom_cs_n),
   .ram_lo_cas_n  (ram_lo_cas_n),
   .ram_hi_cas_n  (ram_hi_cas_n),
   .en245_n       (en245_n),
   .aux_decode_n  (aux_decode_n)
);

`default_nettype wire

// ==== tests/tb_mioc.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mioc;

   localparam int WAIT_LIMIT = 16;            // cycles any wait may take before giving up

   logic                           b_phi;
   logic                           rst_n;
   logic                           game_rst_n;
   logic                           pb_rst_n;
   logic                           io_wr;
   logic [mioc_pkg::IO_ADDR_W-1:0] io_addr;
   logic [mioc_pkg::IO_DATA_W-1:0] io_data;
   logic [2:0]                     addr_hi;
   logic                           mreq_n;
   logic                           rfsh_n;
   logic                           dma_n;
   logic                           busak_n;
   logic                           sys_rst_n;
   logic                           netrst_n;
   logic                           spindis_n;
   logic                           boot_rom_cs_n;
   logic                           aux_rom_cs_n;
   logic                           ram_lo_cas_n;
   logic                           ram_hi_cas_n;
   logic                           en245_n;
   logic                           aux_decode_n;
   logic                           busrq_n;
   logic                           addrbufen_n;

   int          fd;                           // stimulus file handle
   int          cmd;                          // command letter of the current vector
   int          cycles;                       // edges counted by a wait loop
   logic [31:0] fv [9];                       // fields of the current vector

   mioc_top u_dut (.*);

   always #5 b_phi = ~b_phi;                  // 10 ns z80 clock

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TEST FAILED");
      $fatal(1);
   endtask

   task automatic check_val(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
      if (actual !== expected) begin
         abort_run($sformatf("[FAIL] t=%0t %s expected %0h actual %0h",
                             $time, name, expected, actual));
      end
   endtask

   // skips blanks and # lines, gives the next command letter or -1 at eof
   task automatic next_cmd(output int c);
      c = $fgetc(fd);
      while (c == int'(" ") || c == int'("\t") || c == int'("\n") || c == int'("\r")
             || c == int'("#")) begin
         if (c == int'("#")) begin
            while (c != -1 && c != int'("\n")) begin
               c = $fgetc(fd);
            end
         end
         if (c != -1) begin
            c = $fgetc(fd);
         end
      end
   endtask

   task automatic read_fields(input int n);
      int got;
      for (int i = 0; i < n; i++) begin
         got = $fscanf(fd, "%h", fv[i]);
         if (got != 1) begin
            abort_run("stimulus vector has fewer fields than its command needs");
         end
      end
   endtask

   // one-cycle strobe, register loads on the posedge in between
   task automatic write_io();
      io_addr = fv[0][7:0];
      io_data = fv[1][7:0];
      io_wr   = 1'b1;
      @(posedge b_phi);
      @(negedge b_phi);
      io_wr   = 1'b0;
   endtask

   task automatic run_access();
      addr_hi = fv[0][2:0];
      mreq_n  = fv[1][0];
      rfsh_n  = fv[2][0];
      @(posedge b_phi);                       // decode registers here
      @(negedge b_phi);
      check_val("boot_rom_cs_n", fv[3], 32'(boot_rom_cs_n));
      check_val("aux_rom_cs_n", fv[4], 32'(aux_rom_cs_n));
      check_val("ram_lo_cas_n", fv[5], 32'(ram_lo_cas_n));
      check_val("ram_hi_cas_n", fv[6], 32'(ram_hi_cas_n));
      check_val("en245_n", fv[7], 32'(en245_n));
      check_val("aux_decode_n", fv[8], 32'(aux_decode_n));
   endtask

   task automatic set_reset_pins();
      game_rst_n = fv[0][0];
      pb_rst_n   = fv[1][0];
      cycles     = 0;
      while (sys_rst_n !== fv[2][0] && cycles < WAIT_LIMIT) begin
         @(posedge b_phi);
         @(negedge b_phi);
         cycles++;
      end
      if (sys_rst_n !== fv[2][0]) begin
         abort_run("timeout: sys_rst_n never reached its expected level");
      end else begin
         check_val("sys_rst_n latency", fv[3], 32'(cycles));
      end
   endtask

   task automatic set_dma();
      dma_n   = fv[0][0];
      busak_n = fv[1][0];
      cycles  = 0;
      while ((busrq_n !== fv[2][0] || addrbufen_n !== fv[3][0]) && cycles < WAIT_LIMIT) begin
         @(posedge b_phi);
         @(negedge b_phi);
         cycles++;
      end
      if (busrq_n !== fv[2][0] || addrbufen_n !== fv[3][0]) begin
         abort_run("timeout: busrq_n and addrbufen_n never reached their expected levels");
      end else begin
         check_val("busrq_n/addrbufen_n latency", fv[4], 32'(cycles));
      end
   endtask

   initial begin
      b_phi      = 1'b0;
      rst_n      = 1'b0;
      game_rst_n = 1'b1;
      pb_rst_n   = 1'b1;
      io_wr      = 1'b0;
      io_addr    = '0;
      io_data    = '0;
      addr_hi    = '0;
      mreq_n     = 1'b1;                      // bus idle
      rfsh_n     = 1'b1;
      dma_n      = 1'b1;
      busak_n    = 1'b1;
      fd = $fopen("tests/mioc_stimulus.txt", "r");
      if (fd == 0) begin
         abort_run("cannot open tests/mioc_stimulus.txt");
      end
      repeat (10) @(posedge b_phi);
      @(negedge b_phi);
      rst_n = 1'b1;                           // every vector starts on a falling edge
      next_cmd(cmd);
      while (cmd != -1) begin
         if (cmd == int'("W")) begin
            read_fields(2);
            write_io();
         end else if (cmd == int'("A")) begin
            read_fields(9);
            run_access();
         end else if (cmd == int'("R")) begin
            read_fields(4);
            set_reset_pins();
         end else if (cmd == int'("D")) begin
            read_fields(5);
            set_dma();
         end else if (cmd == int'("C")) begin
            read_fields(2);
            check_val("netrst_n", fv[0], 32'(netrst_n));
            check_val("spindis_n", fv[1], 32'(spindis_n));
         end else begin
            abort_run($sformatf("unknown command '%c' in the stimulus file", cmd));
         end
         next_cmd(cmd);
      end
      $fclose(fd);
      $display("TEST PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== tests/mioc_stimulus.txt ====
# W io_addr io_data | A addr_hi mreq_n rfsh_n boot aux_rom ram_lo ram_hi en245 aux_decode
# R game_rst_n pb_rst_n sys_rst_n cycles | D dma_n busak_n busrq_n addrbufen_n cycles | C netrst_n spindis_n
R 1 1 1 0
D 1 1 1 0 0
C 0 0
A 0 0 1 0 1 1 1 1 1
A 4 0 1 1 1 1 0 1 1
A 2 1 1 1 1 1 1 1 1
A 2 0 0 1 1 1 1 1 1
W 7F 05
A 1 0 1 1 1 0 1 1 1
A 6 0 1 1 1 1 1 1 0
W 7F 0A
A 3 0 1 1 1 1 1 1 0
A 5 0 1 1 0 1 1 1 1
W 7F 0F
A 0 0 1 1 1 1 1 0 1
A 3 0 1 1 1 0 1 1 1
A 7 0 1 1 1 1 1 0 1
W 7F 00
W 5F 0F
A 0 0 1 0 1 1 1 1 1
W 3F 03
C 1 1
R 0 1 0 2
R 1 1 1 2
C 0 0
A 0 0 1 1 1 1 1 0 1
A 2 0 1 1 1 0 1 1 1
A 4 0 1 1 1 1 1 0 1
D 0 1 0 0 2
D 0 0 0 1 1
D 0 1 0 0 1
D 0 0 0 1 1
D 1 0 1 0 2
D 1 1 1 0 0

// ==== build.f ====
logic/mioc_pkg.sv
logic/mioc_reset_ctrl.sv
logic/mioc_io_port_reg.sv
logic/mioc_mem_decode.sv
logic/mioc_bus_arbiter.sv
logic/mioc_top.sv
tests/mioc_checker.sv
tests/tb_mioc.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mioc
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
STIMULUS  ?= tests/mioc_stimulus.txt
VFLAGS    ?= --binary --timing --assert

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN) $(STIMULUS)
	./$(BIN) 2>&1 | tee $(LOG)
	grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
